// ==== verilog/capture_settings.svh ====
`ifndef CAPTURE_SETTINGS_SVH
`define CAPTURE_SETTINGS_SVH

// Number of antennas in the array
`define NUM_SIGNALS 8

// FPGA clocks per received symbol
`define CLOCK_RATE 12

// Strobe-free clocks needed before a window counts toward lock
`define CLEAR_GAP 7

// Width of the phase and idle-gap counters
`define PHASE_BITS 4

// Entries in the aligned-word FIFO, a power of two
`define FIFO_DEPTH 8

// Aligned words per accumulation block
`define BLOCK_LEN 16

`endif

// ==== verilog/capture_pkg.sv ====
`default_nettype none

`include "capture_settings.svh"

package capture_pkg;

   // One bit per antenna, gathered on the same symbol
   typedef logic [`NUM_SIGNALS-1:0] sample_word_t;

   // Position within a symbol period, counted in clocks
   typedef logic [`PHASE_BITS-1:0] phase_t;

   // Count of ones seen by one antenna over a block
   // Needs room for BLOCK_LEN itself
   typedef logic [$clog2(`BLOCK_LEN + 1)-1:0] count_t;

   // Per-antenna one-counts for a complete block
   typedef count_t [`NUM_SIGNALS-1:0] block_sums_t;

endpackage

`default_nettype wire

// ==== verilog/signal_capture.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "capture_settings.svh"

module signal_capture import capture_pkg::*; (
   input  wire logic clk,
   input  wire logic rst,
   input  wire logic raw,
   output logic      data,
   output logic      strobe,
   output logic      locked,
   output logic      invalid
);

   // Modulo-CLOCK_RATE addition on phase values
   function automatic phase_t wrap_add(phase_t p, int unsigned n);
      int unsigned s;
      s = p + n;
      return phase_t'(s % `CLOCK_RATE);
   endfunction

   phase_t tick;
   phase_t edge_phase;
   phase_t strobe_phase;
   logic   raw_q;
   logic   edge_seen;
   logic   edge_det;
   logic   near;

   //--------------------------------------------------------------------------
   // Free-running symbol phase and edge detection
   //--------------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         tick  <= '0;
         raw_q <= 1'b0;
      end else begin
         tick  <= (tick == phase_t'(`CLOCK_RATE - 1)) ? '0 : tick + 1'b1;
         raw_q <= raw;
      end
   end

   assign edge_det = raw ^ raw_q;

   // Edge counts as on-phase when within one clock of the stored phase
   assign near = (tick == edge_phase) ||
                 (tick == wrap_add(edge_phase, 1)) ||
                 (tick == wrap_add(edge_phase, `CLOCK_RATE - 1));

   // Mid-symbol point, half a period after the last edge
   assign strobe_phase = wrap_add(edge_phase, `CLOCK_RATE / 2);

   //--------------------------------------------------------------------------
   // Edge phase tracking, lock and phase errors
   //--------------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         edge_phase <= '0;
         edge_seen  <= 1'b0;
         locked     <= 1'b0;
         invalid    <= 1'b0;
      end else if (edge_det) begin
         // Always follow the newest edge
         edge_phase <= tick;
         edge_seen  <= 1'b1;
         locked     <= edge_seen && near;
         // Edge jumped away while locked
         invalid    <= locked && !near;
      end else begin
         invalid <= 1'b0;
      end
   end

   // Strobe once per symbol after the first edge
   always_ff @(posedge clk) begin
      if (rst) begin
         strobe <= 1'b0;
      end else begin
         strobe <= edge_seen && (tick == strobe_phase);
      end
   end

   // Data bit held between strobes
   always_ff @(posedge clk) begin
      if (edge_seen && (tick == strobe_phase)) begin
         data <= raw;
      end
   end

   // One strobe per symbol, even across a phase jump
   a_strobe_single : assert property (@(posedge clk) disable iff (rst)
      strobe |=> !strobe);

endmodule

`default_nettype wire

// ==== verilog/align_captures.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "capture_settings.svh"

module align_captures import capture_pkg::*; (
   input  wire logic                    clk,
   input  wire logic                    rst,
   input  wire sample_word_t            data_in,
   input  wire logic [`NUM_SIGNALS-1:0] strobes,
   input  wire logic [`NUM_SIGNALS-1:0] lockeds,
   input  wire logic [`NUM_SIGNALS-1:0] invalids,
   input  wire logic                    ack,
   output sample_word_t                 data_out,
   output logic                         ready,
   output logic                         locked,
   output logic                         invalid
);

   logic [`NUM_SIGNALS-1:0] arrived;
   logic [`NUM_SIGNALS-1:0] arrived_upd;
   phase_t                  idle;
   logic                    strobe_any;
   logic                    in_window;
   logic                    window_start;
   logic                    window_close;
   logic                    gap_ok;
   logic                    double_strobe;
   logic                    short_gap;
   logic                    capture_error;

   //--------------------------------------------------------------------------
   // Window tracking
   //--------------------------------------------------------------------------
   assign strobe_any   = |strobes;
   assign in_window    = |arrived;
   assign arrived_upd  = arrived | strobes;
   assign window_start = strobe_any && !in_window;
   // Closes on the cycle the final antenna strobes
   assign window_close = &arrived_upd;

   always_ff @(posedge clk) begin
      if (rst) begin
         arrived <= '0;
      end else begin
         arrived <= window_close ? '0 : arrived_upd;
      end
   end

   // Idle clocks since the last window, saturating
   always_ff @(posedge clk) begin
      if (rst) begin
         idle <= '0;
      end else if (strobe_any || in_window) begin
         idle <= '0;
      end else if (idle != '1) begin
         idle <= idle + 1'b1;
      end
   end

   assign gap_ok = idle >= phase_t'(`CLEAR_GAP);

   //--------------------------------------------------------------------------
   // Lock qualification
   //--------------------------------------------------------------------------
   // Decided at the start of each window
   always_ff @(posedge clk) begin
      if (rst) begin
         locked <= 1'b0;
      end else if (window_start) begin
         locked <= gap_ok && (&lockeds);
      end
   end

   //--------------------------------------------------------------------------
   // Aligned word output
   //--------------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         ready <= 1'b0;
      end else begin
         ready <= window_close && locked;
      end
   end

   // Every bit is valid once the last strobe has landed
   always_ff @(posedge clk) begin
      if (window_close) begin
         data_out <= data_in;
      end
   end

   //--------------------------------------------------------------------------
   // Sticky capture error
   //--------------------------------------------------------------------------
   assign double_strobe = |(arrived & strobes);
   assign short_gap     = window_start && !gap_ok;
   assign capture_error = double_strobe || (|invalids) || short_gap;

   always_ff @(posedge clk) begin
      if (rst) begin
         invalid <= 1'b0;
      end else begin
         invalid <= (invalid && !ack) || (locked && capture_error);
      end
   end

   // Relies on every capture strobing at most once per symbol
   a_ready_single : assert property (@(posedge clk) disable iff (rst)
      ready |=> !ready);

endmodule

`default_nettype wire

// ==== verilog/sample_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "capture_settings.svh"

module sample_fifo import capture_pkg::*; #(
   parameter type         payload_t = sample_word_t,
   parameter int unsigned DEPTH     = `FIFO_DEPTH
) (
   input  wire logic     clk,
   input  wire logic     rst,
   input  wire logic     push,
   input  wire payload_t wdata,
   input  wire logic     pop,
   output payload_t      rdata,
   output logic          empty,
   output logic          overflow
);

   localparam int unsigned AW = $clog2(DEPTH);

   payload_t      mem [DEPTH];
   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic [AW:0]   fill;
   logic          full;
   logic          do_push;
   logic          do_pop;

   assign empty   = (fill == '0);
   assign full    = (fill == (AW + 1)'(DEPTH));
   // Words pushed into a full buffer are lost
   assign do_push = push && !full;
   assign do_pop  = pop && !empty;

   // First-word fall-through head
   assign rdata = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr] <= wdata;
      end
   end

   // Pointers wrap naturally at the power-of-two depth
   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         fill     <= '0;
         overflow <= 1'b0;
      end else begin
         wr_ptr   <= wr_ptr + AW'(do_push);
         rd_ptr   <= rd_ptr + AW'(do_pop);
         fill     <= fill + (AW + 1)'(do_push) - (AW + 1)'(do_pop);
         overflow <= overflow || (push && full);
      end
   end

   // Consumer must only pop a valid head
   a_no_pop_empty : assert property (@(posedge clk) disable iff (rst)
      pop |-> !empty);

endmodule

`default_nettype wire

// ==== verilog/block_accumulator.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "capture_settings.svh"

module block_accumulator import capture_pkg::*; (
   input  wire logic         clk,
   input  wire logic         rst,
   input  wire sample_word_t word,
   input  wire logic         empty,
   input  wire logic         hold,
   output logic              pop,
   output block_sums_t       sums,
   output logic              sums_valid
);

   block_sums_t acc;
   block_sums_t acc_next;
   count_t      n_words;
   logic        last_pop;

   // Take the head whenever one is there and nothing holds us
   assign pop = !empty && !hold;

   assign last_pop = pop && (n_words == count_t'(`BLOCK_LEN - 1));

   //--------------------------------------------------------------------------
   // Per-antenna one-count
   //--------------------------------------------------------------------------
   always_comb begin
      for (int i = 0; i < `NUM_SIGNALS; i++) begin
         acc_next[i] = acc[i] + count_t'(word[i]);
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         acc        <= '0;
         n_words    <= '0;
         sums_valid <= 1'b0;
      end else begin
         sums_valid <= last_pop;
         if (last_pop) begin
            // Block complete, start the next one from zero
            acc     <= '0;
            n_words <= '0;
         end else if (pop) begin
            acc     <= acc_next;
            n_words <= n_words + 1'b1;
         end
      end
   end

   // Result register, includes the final word of the block
   always_ff @(posedge clk) begin
      if (last_pop) begin
         sums <= acc_next;
      end
   end

endmodule

`default_nettype wire

// ==== verilog/capture_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "capture_settings.svh"

module capture_top import capture_pkg::*; (
   input  wire logic                    clk,
   input  wire logic                    rst,
   input  wire logic [`NUM_SIGNALS-1:0] raw,
   input  wire logic                    ack,
   input  wire logic                    hold,
   output block_sums_t                  sums,
   output logic                         sums_valid,
   output logic                         locked,
   output logic                         invalid,
   output logic                         overflow
);

   sample_word_t            cap_data;
   logic [`NUM_SIGNALS-1:0] cap_strobes;
   logic [`NUM_SIGNALS-1:0] cap_lockeds;
   logic [`NUM_SIGNALS-1:0] cap_invalids;
   sample_word_t            aligned_word;
   logic                    aligned_ready;
   sample_word_t            head_word;
   logic                    fifo_empty;
   logic                    fifo_pop;

   //--------------------------------------------------------------------------
   // Producer, one capture per antenna then alignment
   //--------------------------------------------------------------------------
   for (genvar i = 0; i < `NUM_SIGNALS; i++) begin : g_capture
      signal_capture capture_i (
         .clk     (clk),
         .rst     (rst),
         .raw     (raw[i]),
         .data    (cap_data[i]),
         .strobe  (cap_strobes[i]),
         .locked  (cap_lockeds[i]),
         .invalid (cap_invalids[i])
      );
   end

   align_captures align_i (
      .clk      (clk),
      .rst      (rst),
      .data_in  (cap_data),
      .strobes  (cap_strobes),
      .lockeds  (cap_lockeds),
      .invalids (cap_invalids),
      .ack      (ack),
      .data_out (aligned_word),
      .ready    (aligned_ready),
      .locked   (locked),
      .invalid  (invalid)
   );

   // Buffer between alignment and accumulation
   sample_fifo #(
      .payload_t (sample_word_t),
      .DEPTH     (`FIFO_DEPTH)
   ) fifo_i (
      .clk      (clk),
      .rst      (rst),
      .push     (aligned_ready),
      .wdata    (aligned_word),
      .pop      (fifo_pop),
      .rdata    (head_word),
      .empty    (fifo_empty),
      .overflow (overflow)
   );

   // Consumer
   block_accumulator accum_i (
      .clk        (clk),
      .rst        (rst),
      .word       (head_word),
      .empty      (fifo_empty),
      .hold       (hold),
      .pop        (fifo_pop),
      .sums       (sums),
      .sums_valid (sums_valid)
   );

endmodule

`default_nettype wire

// ==== test/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
   output logic clk,
   output logic rst
);

   // 8 ns period
   initial clk = 1'b0;
   always #4 clk = ~clk;

   // Reset held for three rising edges
   initial begin
      rst = 1'b1;
      repeat (3) @(posedge clk);
      rst <= 1'b0;
   end

endmodule

`default_nettype wire

// ==== test/capture_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "capture_settings.svh"

module capture_tb import capture_pkg::*; ();

   logic                    clk;
   logic                    rst;
   logic [`NUM_SIGNALS-1:0] raw;
   logic                    ack;
   logic                    hold;
   logic                    hold_q;
   block_sums_t             sums;
   logic                    sums_valid;
   logic                    locked;
   logic                    invalid;
   logic                    overflow;

   int   delay [`NUM_SIGNALS];
   logic [7:0] words [$];
   int   fault_idx;
   int   fault_ant;
   int   hold_start;
   int   hold_end;
   int   n_sym;
   int   cyc = -1;
   int   errors = 0;
   int   checks = 0;
   int   blocks = 0;
   int   blocks_checked = 0;
   int   start = -1;
   int   exp_ones;
   bit   locked_seen;
   bit   inv_rose;
   bit   ovf_seen;
   bit   match;

   tb_clock clock_i (.clk(clk), .rst(rst));

   capture_top dut_i (
      .clk        (clk),
      .rst        (rst),
      .raw        (raw),
      .ack        (ack),
      .hold       (hold),
      .sums       (sums),
      .sums_valid (sums_valid),
      .locked     (locked),
      .invalid    (invalid),
      .overflow   (overflow)
   );

   // Symbol bit repeated CLOCK_RATE times, shifted by the antenna delay
   function automatic logic stream_bit(int a, int c);
      int d;
      int k;
      d = delay[a];
      if (a == fault_ant && c >= fault_idx * `CLOCK_RATE) d = d + 3;
      if (c < d) return 1'b0;
      k = (c - d) / `CLOCK_RATE;
      if (k >= n_sym) return 1'b0;
      return words[k][a];
   endfunction

   // Ones seen by one antenna over BLOCK_LEN symbols from index s
   function automatic int run_ones(int a, int s);
      int n;
      n = 0;
      for (int k = s; k < s + `BLOCK_LEN; k++) n += words[k][a];
      return n;
   endfunction

   // One-bit output expected low
   task automatic check_low(string name, logic value);
      checks++;
      assert (value == 1'b0) else begin
         errors++;
         $display("[ERROR] %0t %s expected 0 got %0b", $time, name, value);
      end
   endtask

   task automatic read_testdata();
      int    fd;
      int    r;
      int    line_no;
      int    w [8];
      string line;
      line_no = 0;
      fd = $fopen("test/capture_testdata.txt", "r");
      assert (fd != 0) else begin
         errors++;
         $display("could not open the test data file");
      end
      while (fd != 0 && !$feof(fd)) begin
         r = $fgets(line, fd);
         if (r == 0 || line.len() < 2 || line.getc(0) == "#") continue;
         if (line_no == 0) begin
            r = $sscanf(line, "%d %d %d %d %d %d %d %d", delay[0], delay[1], delay[2],
                        delay[3], delay[4], delay[5], delay[6], delay[7]);
         end else if (line_no == 1) begin
            r = $sscanf(line, "%d %d %d %d", fault_idx, fault_ant, hold_start, hold_end);
         end else begin
            r = $sscanf(line, "%h %h %h %h %h %h %h %h", w[0], w[1], w[2], w[3],
                        w[4], w[5], w[6], w[7]);
            for (int i = 0; i < r; i++) words.push_back(w[i][7:0]);
         end
         line_no++;
      end
      if (fd != 0) $fclose(fd);
      n_sym = words.size();
   endtask

   // Watchdog sized from the symbol count
   initial begin
      wait (n_sym > 0);
      #(n_sym * `CLOCK_RATE * 2 * 8);
      $display("timeout, the run did not finish in time");
      $display(">>> FAIL");
      $finish;
   end

   //---------------------------------------------------------------------------
   // Output monitors, sampled on the falling edge
   //---------------------------------------------------------------------------
   always @(negedge clk) begin
      if (cyc >= 0) begin
         if (locked) locked_seen = 1;
         // No errors during the clean run
         if (cyc < fault_idx * `CLOCK_RATE) begin
            check_low("invalid", invalid);
         end
         if (cyc >= fault_idx * `CLOCK_RATE && invalid) inv_rose = 1;
         if (!inv_rose && cyc == (fault_idx + 2) * `CLOCK_RATE) begin
            assert (0) else begin
               errors++;
               $display("invalid did not rise within two symbols of the delay jump");
            end
         end
         // Sticky until ack, clear after it
         if (inv_rose && cyc < (fault_idx + 10) * `CLOCK_RATE) begin
            checks++;
            assert (invalid) else begin
               errors++;
               $display("[ERROR] %0t invalid expected 1 got %0b", $time, invalid);
            end
         end
         if (cyc >= (fault_idx + 10) * `CLOCK_RATE + 2) begin
            check_low("invalid", invalid);
         end
         // FIFO drains freely before the long hold
         if (cyc < hold_start * `CLOCK_RATE) begin
            check_low("overflow", overflow);
         end
         if (overflow) ovf_seen = 1;
         if (ovf_seen) begin
            assert (overflow) else begin
               errors++;
               $display("[ERROR] %0t overflow expected 1 got %0b", $time, overflow);
            end
         end
         if (hold && hold_q) begin
            check_low("sums_valid", sums_valid);
         end
      end
      if (sums_valid && cyc >= 0) begin
         if (blocks == 0) begin
            assert (locked_seen) else begin
               errors++;
               $display("first block completed before lock");
            end
            // Locate the run of symbols that the first block covers
            for (int s = 0; s + `BLOCK_LEN <= n_sym && start < 0; s++) begin
               match = 1;
               for (int a = 0; a < `NUM_SIGNALS; a++)
                  if (sums[a] != count_t'(run_ones(a, s))) match = 0;
               if (match) start = s;
            end
            assert (start >= 0) else begin
               errors++;
               $display("first block matches no run of consecutive symbols");
            end
         end else if (start >= 0 &&
                      start + (blocks + 1) * `BLOCK_LEN - 1 < fault_idx - 1) begin
            for (int a = 0; a < `NUM_SIGNALS; a++) begin
               exp_ones = run_ones(a, start + blocks * `BLOCK_LEN);
               checks++;
               assert (sums[a] == count_t'(exp_ones)) else begin
                  errors++;
                  $display("[ERROR] %0t sums[%0d] expected %0d got %0d",
                           $time, a, exp_ones, sums[a]);
               end
            end
            blocks_checked++;
         end
         blocks++;
      end
   end

   //---------------------------------------------------------------------------
   // Stimulus
   //---------------------------------------------------------------------------
   initial begin
      raw    = '0;
      ack    = 1'b0;
      hold   = 1'b0;
      hold_q = 1'b0;
      read_testdata();
      wait (rst === 1'b0);
      @(negedge clk);
      check_low("locked", locked);
      check_low("invalid", invalid);
      check_low("overflow", overflow);
      check_low("sums_valid", sums_valid);
      for (int c = 0; c < (n_sym + 4) * `CLOCK_RATE; c++) begin
         @(posedge clk);
         cyc = c;
         for (int a = 0; a < `NUM_SIGNALS; a++) raw[a] <= stream_bit(a, c);
         ack    <= (c == (fault_idx + 10) * `CLOCK_RATE);
         hold   <= (c >= hold_start * `CLOCK_RATE) && (c < hold_end * `CLOCK_RATE);
         hold_q <= hold;
      end
      @(negedge clk);
      assert (ovf_seen) else begin
         errors++;
         $display("overflow never rose during the long hold");
      end
      assert (blocks_checked >= 2) else begin
         errors++;
         $display("too few aligned blocks were checked");
      end
      $display("checks %0d, blocks %0d, errors %0d", checks, blocks, errors);
      if (errors == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== test/capture_testdata.txt ====
# Line 1: per-antenna delay in clocks, antenna 0 first
# Line 2: fault symbol, fault antenna, hold start symbol, hold end symbol; then symbol words in hex
2 3 4 5 3 4 5 4
60 0 76 90
ff 00 ff 00 5a c3 96 3c
e1 7b 24 d8 9f 42 b5 6e
13 a7 c9 58 f0 2d 8b 64
31 ec 47 9a d2 0f 76 b8
5d 83 2a e6 19 c4 7f 30
a9 56 d7 0b 68 f3 94 21
cd 3e 85 72 1a eb 49 b6
07 d9 64 a2 5f 80 3b c7
8e 15 f6 43 b9 2c 7d 91
4b e0 36 ad 58 c2 1f 97
6a d3 0c b4 e7 29 85 5b
f1 4e 92 37 cb 60 a5 1d

// ==== flist.f ====
+incdir+verilog
verilog/capture_pkg.sv
verilog/signal_capture.sv
verilog/align_captures.sv
verilog/sample_fifo.sv
verilog/block_accumulator.sv
verilog/capture_top.sv
test/tb_clock.sv
test/capture_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the capture testbench with Verilator
cd "$(dirname "$0")" || exit 1
set -o pipefail

verilator --binary --timing --assert --top-module capture_tb -f flist.f -o capture_sim \
   && ./obj_dir/capture_sim 2>&1 | tee sim.log \
   || { echo "build or simulation failed"; exit 1; }

grep -q '^>>> FAIL' sim.log && { echo "testbench reported failure"; exit 1; }
grep -q '^>>> PASS' sim.log || { echo "no pass line in log"; exit 1; }
exit 0
